//--- src.f
hdl/mem_wb_pkg.sv
hdl/mem_cmd_if.sv
hdl/wb_bus_if.sv
hdl/mem_cmd_fifo.sv
hdl/mem_wb_master.sv
hdl/wb_ram.sv
hdl/mem_wb_top.sv
verification/mem_wb_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the memory-to-Wishbone bridge testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module mem_wb_tb -o mem_wb_sim \
  || { echo "Build failed"; exit 1; }

sim_out=$(./obj_dir/mem_wb_sim)
echo "$sim_out"
echo "$sim_out" | grep -q "^TB PASSED$" && echo "Result: pass" || { echo "Result: fail"; exit 1; }

//--- verification/mem_wb_tb.sv
`default_nettype none

module mem_wb_tb
  import mem_wb_pkg::*;
();

  localparam int addr_width_lp = 12;
  localparam int mem_bytes_lp  = 1 << addr_width_lp;
  localparam int dwords_lp     = mem_bytes_lp / 8;
  localparam int timeout_lp    = 200;

  logic                     clk_i;
  logic                     rst_n_i;
  logic                     cmd_v_i;
  logic                     cmd_ready_and_o;
  mem_op_t                  cmd_op_i;
  logic [addr_width_lp-1:0] cmd_addr_i;
  mem_size_t                cmd_size_i;
  dword_t                   cmd_data_i;
  logic                     resp_v_o;
  logic                     resp_ready_and_i;
  mem_op_t                  resp_op_o;
  logic [addr_width_lp-1:0] resp_addr_o;
  mem_size_t                resp_size_o;
  dword_t                   resp_data_o;

  // Byte-array model of the RAM and the expected responses in order.
  logic [7:0]               mem_model [mem_bytes_lp];
  mem_op_t                  exp_op_q [$];
  logic [addr_width_lp-1:0] exp_addr_q [$];
  mem_size_t                exp_size_q [$];
  dword_t                   exp_data_q [$];

  int   mismatch_errors = 0;
  int   other_errors    = 0;
  int   cmd_count       = 0;
  int   resp_count      = 0;
  logic hold_stall      = 1'b0;

  mem_wb_top #(.addr_width_p(addr_width_lp)) UUT (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .cmd_v_i          (cmd_v_i),
    .cmd_ready_and_o  (cmd_ready_and_o),
    .cmd_op_i         (cmd_op_i),
    .cmd_addr_i       (cmd_addr_i),
    .cmd_size_i       (cmd_size_i),
    .cmd_data_i       (cmd_data_i),
    .resp_v_o         (resp_v_o),
    .resp_ready_and_i (resp_ready_and_i),
    .resp_op_o        (resp_op_o),
    .resp_addr_o      (resp_addr_o),
    .resp_size_o      (resp_size_o),
    .resp_data_o      (resp_data_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // ----------------------------------------------------------------------
  // Reference model helpers.
  // ----------------------------------------------------------------------
  function automatic int size_bytes(input mem_size_t size);
    return 1 << size;
  endfunction

  function automatic logic [addr_width_lp-1:0] align_addr(input logic [addr_width_lp-1:0] addr,
                                                          input mem_size_t size);
    logic [31:0] full;
    full = {{(32 - addr_width_lp){1'b0}}, addr};
    full = full & ~(size_bytes(size) - 1);
    return full[addr_width_lp-1:0];
  endfunction

  function automatic logic [addr_width_lp-1:0] dword_addr(input int index);
    logic [31:0] full;
    full = index * 8;
    return full[addr_width_lp-1:0];
  endfunction

  // Bytes above the size stay zero.
  function automatic dword_t model_read(input logic [addr_width_lp-1:0] addr, input int n);
    dword_t result;
    result = '0;
    for (int i = 0; i < n; i++) begin
      result[8*i +: 8] = mem_model[int'(addr) + i];
    end
    return result;
  endfunction

  task automatic model_write(input logic [addr_width_lp-1:0] addr, input int n,
                             input dword_t data);
    for (int i = 0; i < n; i++) begin
      mem_model[int'(addr) + i] = data[8*i +: 8];
    end
  endtask

  // ----------------------------------------------------------------------
  // Compare tasks and run summary.
  // ----------------------------------------------------------------------
  task automatic check_op(input mem_op_t got, input mem_op_t exp);
    if (got !== exp) begin
      mismatch_errors++;
      $display("Mismatch at %0t: resp_op_o got %0h, expected %0h", $time, got, exp);
    end
  endtask

  task automatic check_addr(input logic [addr_width_lp-1:0] got,
                            input logic [addr_width_lp-1:0] exp);
    if (got !== exp) begin
      mismatch_errors++;
      $display("Mismatch at %0t: resp_addr_o got %0h, expected %0h", $time, got, exp);
    end
  endtask

  task automatic check_size(input mem_size_t got, input mem_size_t exp);
    if (got !== exp) begin
      mismatch_errors++;
      $display("Mismatch at %0t: resp_size_o got %0h, expected %0h", $time, got, exp);
    end
  endtask

  task automatic check_data(input dword_t got, input dword_t exp);
    if (got !== exp) begin
      mismatch_errors++;
      $display("Mismatch at %0t: resp_data_o got %016h, expected %016h", $time, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      mismatch_errors++;
      $display("Mismatch at %0t: %s got %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic finish_run();
    $display("Summary: %0d mismatches, %0d other errors, %0d commands, %0d responses",
             mismatch_errors, other_errors, cmd_count, resp_count);
    if (mismatch_errors == 0 && other_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  endtask

  task automatic report_timeout(input string what);
    other_errors++;
    $display("Error at %0t: %s did not happen within %0d cycles", $time, what, timeout_lp);
    finish_run();
  endtask

  // ----------------------------------------------------------------------
  // Stimulus tasks, called 2 units after a rising edge.
  // ----------------------------------------------------------------------
  task automatic send_cmd(input mem_op_t op, input logic [addr_width_lp-1:0] addr,
                          input mem_size_t size, input dword_t data);
    int                       waited;
    logic [addr_width_lp-1:0] aligned;
    waited     = 0;
    cmd_v_i    = 1'b1;
    cmd_op_i   = op;
    cmd_addr_i = addr;
    cmd_size_i = size;
    cmd_data_i = data;
    @(negedge clk_i);
    while (!cmd_ready_and_o) begin
      waited++;
      if (waited >= timeout_lp) report_timeout("Command acceptance");
      @(negedge clk_i);
    end
    // Accepted on the coming edge, so the expected response is fixed now.
    aligned = align_addr(addr, size);
    exp_op_q.push_back(op);
    exp_addr_q.push_back(aligned);
    exp_size_q.push_back(size);
    if (op == MEM_OP_WRITE) begin
      model_write(aligned, size_bytes(size), data);
      exp_data_q.push_back('0);
    end else begin
      exp_data_q.push_back(model_read(aligned, size_bytes(size)));
    end
    cmd_count++;
    @(posedge clk_i);
    #2;
    cmd_v_i = 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_op_q.size() != 0) begin
      waited++;
      if (waited >= timeout_lp) report_timeout("Response drain");
      @(posedge clk_i);
    end
    #2;
  endtask

  task automatic random_cmd(input logic allow_write, input logic allow_dword);
    logic [31:0] rnd;
    mem_op_t     op;
    mem_size_t   size;
    rnd  = $urandom;
    op   = allow_write ? rnd[0] : MEM_OP_READ;
    size = allow_dword ? rnd[2:1] : mem_size_t'($urandom_range(2));
    rnd  = $urandom;
    send_cmd(op, rnd[addr_width_lp-1:0], size, {$urandom, $urandom});
  endtask

  // Random back-pressure on the response channel.
  initial begin
    forever begin
      @(posedge clk_i);
      #2;
      resp_ready_and_i = hold_stall ? 1'b0 : ($urandom_range(3) != 0);
    end
  end

  // Response monitor, sampling where outputs are settled.
  initial begin
    forever begin
      @(negedge clk_i);
      if (rst_n_i && resp_v_o && resp_ready_and_i) begin
        if (exp_op_q.size() == 0) begin
          other_errors++;
          $display("Error at %0t: response arrived with no command outstanding", $time);
        end else begin
          check_op(resp_op_o, exp_op_q.pop_front());
          check_addr(resp_addr_o, exp_addr_q.pop_front());
          check_size(resp_size_o, exp_size_q.pop_front());
          check_data(resp_data_o, exp_data_q.pop_front());
        end
        resp_count++;
      end
    end
  end

  initial begin
    int waited;
    void'($urandom(32'h5cb0));
    rst_n_i          = 1'b0;
    cmd_v_i          = 1'b0;
    cmd_op_i         = MEM_OP_READ;
    cmd_addr_i       = '0;
    cmd_size_i       = MEM_SIZE_1;
    cmd_data_i       = '0;
    resp_ready_and_i = 1'b0;
    repeat (5) @(posedge clk_i);
    #2;
    rst_n_i = 1'b1;

    @(negedge clk_i);
    check_flag("cmd_ready_and_o", cmd_ready_and_o, 1'b1);
    check_flag("resp_v_o", resp_v_o, 1'b0);
    @(posedge clk_i);
    #2;

    // Fill every dword, then read all of it back.
    for (int d = 0; d < dwords_lp; d++) send_cmd(MEM_OP_WRITE, dword_addr(d), MEM_SIZE_8,
                                                 {$urandom, $urandom});
    for (int d = 0; d < dwords_lp; d++) send_cmd(MEM_OP_READ, dword_addr(d), MEM_SIZE_8, '0);
    wait_drain();

    // Narrow writes, then full dword reads.
    repeat (200) random_cmd(1'b1, 1'b0);
    for (int d = 0; d < dwords_lp; d++) send_cmd(MEM_OP_READ, dword_addr(d), MEM_SIZE_8, '0);
    wait_drain();

    // Narrow reads at unaligned addresses.
    repeat (200) random_cmd(1'b0, 1'b0);
    wait_drain();

    // One command in the adapter and two in the buffer fill the path.
    hold_stall = 1'b1;
    repeat (3) random_cmd(1'b1, 1'b1);
    waited = 0;
    @(negedge clk_i);
    while (!resp_v_o) begin
      waited++;
      if (waited >= timeout_lp) report_timeout("Stalled response");
      @(negedge clk_i);
    end
    repeat (4) begin
      check_flag("cmd_ready_and_o", cmd_ready_and_o, 1'b0);
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #2;
    hold_stall = 1'b0;
    wait_drain();

    repeat (400) random_cmd(1'b1, 1'b1);
    wait_drain();

    if (resp_count != cmd_count) begin
      mismatch_errors++;
      $display("Mismatch at %0t: response count got %0d, expected %0d",
               $time, resp_count, cmd_count);
    end
    finish_run();
  end

endmodule

`default_nettype wire

//--- hdl/mem_wb_top.sv
`default_nettype none

module mem_wb_top
  import mem_wb_pkg::*;
#(
  parameter int addr_width_p = 12
) (
  input  logic                    clk_i,
  input  logic                    rst_n_i,

  // Command channel.
  input  logic                    cmd_v_i,
  output logic                    cmd_ready_and_o,
  input  mem_op_t                 cmd_op_i,
  input  logic [addr_width_p-1:0] cmd_addr_i,
  input  mem_size_t               cmd_size_i,
  input  dword_t                  cmd_data_i,

  // Response channel.
  output logic                    resp_v_o,
  input  logic                    resp_ready_and_i,
  output mem_op_t                 resp_op_o,
  output logic [addr_width_p-1:0] resp_addr_o,
  output mem_size_t               resp_size_o,
  output dword_t                  resp_data_o
);

  mem_cmd_if #(.addr_width_p(addr_width_p)) cmd_buf_if ();
  wb_bus_if  #(.addr_width_p(addr_width_p)) wb_if ();

  // ------------------------------------------------------------------
  // Command buffer, adapter and RAM.
  // ------------------------------------------------------------------
  mem_cmd_fifo #(.addr_width_p(addr_width_p)) u_cmd_fifo (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .cmd_v_i         (cmd_v_i),
    .cmd_ready_and_o (cmd_ready_and_o),
    .cmd_op_i        (cmd_op_i),
    .cmd_addr_i      (cmd_addr_i),
    .cmd_size_i      (cmd_size_i),
    .cmd_data_i      (cmd_data_i),
    .deq             (cmd_buf_if.source)
  );

  mem_wb_master #(.addr_width_p(addr_width_p)) u_wb_master (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .cmd              (cmd_buf_if.sink),
    .wb               (wb_if.master),
    .resp_v_o         (resp_v_o),
    .resp_ready_and_i (resp_ready_and_i),
    .resp_op_o        (resp_op_o),
    .resp_addr_o      (resp_addr_o),
    .resp_size_o      (resp_size_o),
    .resp_data_o      (resp_data_o)
  );

  wb_ram #(.addr_width_p(addr_width_p)) u_wb_ram (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .wb      (wb_if.slave)
  );

endmodule

`default_nettype wire

//--- hdl/wb_ram.sv
`default_nettype none

module wb_ram
  import mem_wb_pkg::*;
#(
  parameter int addr_width_p = 12
) (
  input  logic    clk_i,
  input  logic    rst_n_i,

  wb_bus_if.slave wb
);

  localparam int lanes_lp = DWORD_WIDTH / 8;
  localparam int depth_lp = (1 << addr_width_p) / lanes_lp;

  dword_t mem_r [depth_lp];
  dword_t dat_r;
  logic   ack_r;
  logic   req;

  // A request is served once because the ack cycle blocks a repeat.
  assign req = wb.cyc && wb.stb && !ack_r;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ack_r <= 1'b0;
    end else begin
      ack_r <= req;
    end
  end

  // ------------------------------------------------------------------
  // Storage with per-lane write enables.
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (req) begin
      if (wb.we) begin
        for (int i = 0; i < lanes_lp; i++) begin
          if (wb.sel[i]) begin
            mem_r[wb.adr][8*i +: 8] <= wb.dat_mosi[8*i +: 8];
          end
        end
      end
      dat_r <= mem_r[wb.adr];
    end
  end

  assign wb.ack      = ack_r;
  assign wb.dat_miso = dat_r;

  // Ack answers a strobe that was raised the cycle before and is still held.
  a_ack_after_stb: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb.ack |-> wb.stb && $past(wb.stb));

endmodule

`default_nettype wire

//--- hdl/mem_wb_master.sv
`default_nettype none

module mem_wb_master
  import mem_wb_pkg::*;
#(
  parameter int addr_width_p = 12
) (
  input  logic                    clk_i,
  input  logic                    rst_n_i,

  mem_cmd_if.sink                 cmd,
  wb_bus_if.master                wb,

  output logic                    resp_v_o,
  input  logic                    resp_ready_and_i,
  output mem_op_t                 resp_op_o,
  output logic [addr_width_p-1:0] resp_addr_o,
  output mem_size_t               resp_size_o,
  output dword_t                  resp_data_o
);

  // Byte lanes that a size covers from lane zero.
  function automatic sel_t size_lanes(input mem_size_t size);
    case (size)
      MEM_SIZE_1: return 8'h01;
      MEM_SIZE_2: return 8'h03;
      MEM_SIZE_4: return 8'h0f;
      default:    return 8'hff;
    endcase
  endfunction

  // Expands each lane bit into a full byte mask.
  function automatic dword_t lane_mask(input sel_t lanes);
    dword_t mask;
    for (int i = 0; i < DWORD_WIDTH / 8; i++) begin
      mask[8*i +: 8] = {8{lanes[i]}};
    end
    return mask;
  endfunction

  wbm_state_e state_r;

  // Latched command.
  mem_op_t                 op_r;
  logic [addr_width_p-1:0] addr_r;
  mem_size_t               size_r;
  sel_t                    sel_r;
  dword_t                  wdata_r;
  dword_t                  resp_data_r;

  logic [addr_width_p-1:0] cmd_addr_aligned;
  logic [2:0]              cmd_offset;
  logic [2:0]              bus_offset;
  dword_t                  rdata_shifted;
  logic                    cmd_fire;
  logic                    bus_done;

  // ------------------------------------------------------------------
  // Address alignment and lane placement.
  // ------------------------------------------------------------------
  always_comb begin
    cmd_addr_aligned = cmd.addr;
    case (cmd.size)
      MEM_SIZE_2: cmd_addr_aligned[0]   = 1'b0;
      MEM_SIZE_4: cmd_addr_aligned[1:0] = 2'b00;
      MEM_SIZE_8: cmd_addr_aligned[2:0] = 3'b000;
      default:    cmd_addr_aligned      = cmd.addr;
    endcase
  end

  assign cmd_offset    = cmd_addr_aligned[2:0];
  assign bus_offset    = addr_r[2:0];
  assign rdata_shifted = wb.dat_miso >> {bus_offset, 3'b000};

  assign cmd.ready_and = (state_r == IDLE);
  assign cmd_fire      = cmd.v && cmd.ready_and;
  assign bus_done      = wb.stb && wb.ack;

  // ------------------------------------------------------------------
  // Control FSM.
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_r <= IDLE;
    end else begin
      case (state_r)
        IDLE:    if (cmd_fire) state_r <= BUS;
        BUS:     if (bus_done) state_r <= RESP;
        RESP:    if (resp_ready_and_i) state_r <= IDLE;
        default: state_r <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_fire) begin
      op_r    <= cmd.op;
      addr_r  <= cmd_addr_aligned;
      size_r  <= cmd.size;
      sel_r   <= size_lanes(cmd.size) << cmd_offset;
      wdata_r <= cmd.data << {cmd_offset, 3'b000};
    end
    // Writes return zero data.
    if (state_r == BUS && bus_done) begin
      resp_data_r <= (op_r == MEM_OP_WRITE) ? '0
                                            : rdata_shifted & lane_mask(size_lanes(size_r));
    end
  end

  // Single-beat classic cycle.
  assign wb.cyc      = (state_r == BUS);
  assign wb.stb      = (state_r == BUS);
  assign wb.adr      = addr_r[addr_width_p-1:3];
  assign wb.sel      = sel_r;
  assign wb.we       = (op_r == MEM_OP_WRITE);
  assign wb.dat_mosi = wdata_r;

  assign resp_v_o    = (state_r == RESP);
  assign resp_op_o   = op_r;
  assign resp_addr_o = addr_r;
  assign resp_size_o = size_r;
  assign resp_data_o = resp_data_r;

  // ------------------------------------------------------------------
  // Wishbone protocol checks.
  // ------------------------------------------------------------------
  a_drop_after_ack: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    bus_done |=> !wb.cyc && !wb.stb);

  a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (wb.stb && !wb.ack) |=> $stable(wb.adr) && $stable(wb.sel) && $stable(wb.we));

endmodule

`default_nettype wire

//--- hdl/mem_cmd_fifo.sv
`default_nettype none

module mem_cmd_fifo
  import mem_wb_pkg::*;
#(
  parameter int addr_width_p = 12
) (
  input  logic                    clk_i,
  input  logic                    rst_n_i,

  input  logic                    cmd_v_i,
  output logic                    cmd_ready_and_o,
  input  mem_op_t                 cmd_op_i,
  input  logic [addr_width_p-1:0] cmd_addr_i,
  input  mem_size_t               cmd_size_i,
  input  dword_t                  cmd_data_i,

  mem_cmd_if.source               deq
);

  // Two-entry storage.
  mem_op_t                 op_mem   [2];
  logic [addr_width_p-1:0] addr_mem [2];
  mem_size_t               size_mem [2];
  dword_t                  data_mem [2];

  logic       wr_ptr_r;
  logic       rd_ptr_r;
  logic [1:0] count_r;
  logic       push;
  logic       pop;

  assign deq.v  = (count_r != 2'd0);
  assign pop    = deq.v && deq.ready_and;

  // A full buffer still takes a command when the head leaves this cycle.
  assign cmd_ready_and_o = (count_r != 2'd2) || deq.ready_and;
  assign push            = cmd_v_i && cmd_ready_and_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_r <= 1'b0;
      rd_ptr_r <= 1'b0;
      count_r  <= 2'd0;
    end else begin
      if (push) wr_ptr_r <= ~wr_ptr_r;
      if (pop) rd_ptr_r <= ~rd_ptr_r;
      case ({push, pop})
        2'b10:   count_r <= count_r + 2'd1;
        2'b01:   count_r <= count_r - 2'd1;
        default: count_r <= count_r;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      op_mem[wr_ptr_r]   <= cmd_op_i;
      addr_mem[wr_ptr_r] <= cmd_addr_i;
      size_mem[wr_ptr_r] <= cmd_size_i;
      data_mem[wr_ptr_r] <= cmd_data_i;
    end
  end

  // Oldest entry is always presented.
  assign deq.op   = op_mem[rd_ptr_r];
  assign deq.addr = addr_mem[rd_ptr_r];
  assign deq.size = size_mem[rd_ptr_r];
  assign deq.data = data_mem[rd_ptr_r];

  // ------------------------------------------------------------------
  // Occupancy checks.
  // ------------------------------------------------------------------
  a_count_max: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    count_r <= 2'd2);

  // Pointers differ only while exactly one entry is held.
  a_ptr_count: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (wr_ptr_r == rd_ptr_r) == (count_r != 2'd1));

endmodule

`default_nettype wire

//--- hdl/wb_bus_if.sv
`default_nettype none

interface wb_bus_if
  import mem_wb_pkg::*;
#(
  parameter int addr_width_p = 12
) ();

  // Dword address, the low three byte bits are carried by sel.
  logic [addr_width_p-4:0] adr;
  dword_t                  dat_mosi;
  dword_t                  dat_miso;
  logic                    cyc;
  logic                    stb;
  sel_t                    sel;
  logic                    we;
  logic                    ack;

  modport master (output adr, output dat_mosi, output cyc, output stb,
                  output sel, output we,
                  input dat_miso, input ack);

  modport slave (input adr, input dat_mosi, input cyc, input stb,
                 input sel, input we,
                 output dat_miso, output ack);

endinterface

`default_nettype wire

//--- hdl/mem_cmd_if.sv
`default_nettype none

interface mem_cmd_if
  import mem_wb_pkg::*;
#(
  parameter int addr_width_p = 12
) ();

  logic                    v;
  logic                    ready_and;
  mem_op_t                 op;
  logic [addr_width_p-1:0] addr;
  mem_size_t               size;
  dword_t                  data;

  // Fields must hold while v waits for ready_and.
  modport source (output v, output op, output addr, output size, output data,
                  input ready_and);

  modport sink (input v, input op, input addr, input size, input data,
                output ready_and);

endinterface

`default_nettype wire

//--- hdl/mem_wb_pkg.sv
`default_nettype none

package mem_wb_pkg;

  // ------------------------------------------------------------------
  // Bus widths and data types.
  // ------------------------------------------------------------------
  localparam int DWORD_WIDTH = 64;

  typedef logic [DWORD_WIDTH-1:0]     dword_t;
  typedef logic [(DWORD_WIDTH/8)-1:0] sel_t;

  // ------------------------------------------------------------------
  // Command encodings.
  // ------------------------------------------------------------------
  typedef logic [0:0] mem_op_t;

  localparam mem_op_t MEM_OP_READ  = 1'b0;
  localparam mem_op_t MEM_OP_WRITE = 1'b1;

  // Size code is log2 of the byte count.
  typedef logic [1:0] mem_size_t;

  localparam mem_size_t MEM_SIZE_1 = 2'd0;
  localparam mem_size_t MEM_SIZE_2 = 2'd1;
  localparam mem_size_t MEM_SIZE_4 = 2'd2;
  localparam mem_size_t MEM_SIZE_8 = 2'd3;

  // Wishbone master adapter states.
  typedef enum logic [1:0] {
    IDLE,
    BUS,
    RESP
  } wbm_state_e;

endpackage

`default_nettype wire
